/* build.f */
src/sd_bus_pkg.sv
src/mem_pkg.sv
src/sd_dma_fsm.sv
src/sd_clk_timer.sv
src/nibble_packer.sv
src/sram_writer.sv
src/sd_dma_top.sv
tests/sd_card_model.sv
tests/tb_sd_dma.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the SD DMA testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tb_sd_dma -f build.f

# The log decides the result, so a non-zero exit from the run is kept going
./obj_dir/Vtb_sd_dma > sim.log 2>&1 || true
cat sim.log

if grep -qx "SIMULATION PASSED" sim.log; then
  echo "run_sim.sh: test run passed"
  exit 0
else
  echo "run_sim.sh: test run failed, see sim.log"
  exit 1
fi

/* src/mem_pkg.sv */
`default_nettype none

package mem_pkg;

  //////////////////////////////
  // Destination SRAM
  //////////////////////////////

  // Byte-wide data port
  typedef logic [7:0] byte_t;

  // Byte address, 512K deep
  typedef logic [18:0] sram_addr_t;

endpackage

`default_nettype wire

/* src/nibble_packer.sv */
`default_nettype none

module nibble_packer (
  input  wire                     CLK,
  input  wire                     reset,
  input  wire                     clear,
  input  wire                     run,
  input  wire                     sample,
  input  sd_bus_pkg::frame_cnt_t  nibble_idx,
  input  sd_bus_pkg::nibble_t     sd_dat,
  input  sd_bus_pkg::byte_idx_t   win_lo,
  input  sd_bus_pkg::byte_idx_t   win_hi_incl,
  input  wire                     byte_ready,
  output logic                    byte_valid,
  output mem_pkg::byte_t          byte_data,
  output logic                    stall,
  output logic                    window_end
);

  import sd_bus_pkg::*;

  localparam frame_cnt_t FIRST_DATA = frame_cnt_t'(DATA_FIRST_NIBBLE);
  localparam frame_cnt_t LAST_DATA  = frame_cnt_t'(DATA_FIRST_NIBBLE + 2 * BLOCK_BYTES - 1);

  frame_cnt_t data_off;
  byte_idx_t  byte_k;
  logic       is_data;
  logic       is_low;
  logic       in_window;
  logic       take_byte;
  nibble_t    hi_nib;
  logic       last_q;

  //////////////////////////////
  // Nibble position decode
  //////////////////////////////

  assign is_data   = (nibble_idx >= FIRST_DATA) && (nibble_idx <= LAST_DATA);
  assign data_off  = nibble_idx - FIRST_DATA;
  // Odd offset is the low half of the byte
  assign is_low    = data_off[0];
  assign byte_k    = data_off[9:1];
  assign in_window = (byte_k >= win_lo) && (byte_k <= win_hi_incl);
  assign take_byte = sample && is_data && is_low && in_window;

  // Next sample would finish a byte while the current one is still held
  assign stall      = run && byte_valid && !byte_ready && is_data && is_low;
  assign window_end = byte_valid && byte_ready && last_q;

  always_ff @(posedge CLK) begin
    if (reset || clear) begin
      byte_valid <= 1'b0;
      last_q     <= 1'b0;
    end else begin
      if (byte_valid && byte_ready) begin
        byte_valid <= 1'b0;
      end
      if (take_byte) begin
        byte_valid <= 1'b1;
        last_q     <= (byte_k == win_hi_incl);
      end
    end
  end

  // High half waits here for its partner
  always_ff @(posedge CLK) begin
    if (sample && is_data && !is_low) begin
      hi_nib <= sd_dat;
    end
    if (take_byte) begin
      byte_data <= {hi_nib, sd_dat};
    end
  end

endmodule

`default_nettype wire

/* src/sd_bus_pkg.sv */
`default_nettype none

package sd_bus_pkg;

  //////////////////////////////
  // DAT bus types
  //////////////////////////////

  // One value on the four DAT lines
  typedef logic [3:0] nibble_t;

  // Nibble position in a frame, 0 to 1041
  typedef logic [10:0] frame_cnt_t;

  // Byte offset inside one block
  typedef logic [8:0] byte_idx_t;

  // Position inside one SD clock period
  typedef logic [1:0] sd_phase_t;

  //////////////////////////////
  // Frame geometry
  //////////////////////////////

  // Start nibble, 1024 data nibbles, 16 CRC nibbles, stop nibble
  localparam int FRAME_NIBBLES     = 1042;
  localparam int DATA_FIRST_NIBBLE = 1;
  localparam int BLOCK_BYTES       = 512;

  // SD clock is CLK divided by four
  localparam int CLKS_PER_SD  = 4;
  // DAT is taken on the rising SD edge
  localparam int SAMPLE_PHASE = 2;

endpackage

`default_nettype wire

/* src/sd_clk_timer.sv */
`default_nettype none

module sd_clk_timer (
  input  wire                     CLK,
  input  wire                     reset,
  input  wire                     run,
  input  wire                     clear,
  input  wire                     stall,
  output logic                    sd_clk,
  output logic                    sample,
  output sd_bus_pkg::frame_cnt_t  nibble_idx,
  output logic                    frame_end
);

  import sd_bus_pkg::*;

  localparam sd_phase_t  LAST_PHASE  = sd_phase_t'(CLKS_PER_SD - 1);
  localparam sd_phase_t  EDGE_PHASE  = sd_phase_t'(SAMPLE_PHASE);
  localparam frame_cnt_t LAST_NIBBLE = frame_cnt_t'(FRAME_NIBBLES - 1);

  sd_phase_t phase;
  logic      finished;
  logic      active;
  logic      advance;

  // Clock runs until the last nibble has been taken
  assign active  = run && !finished;
  assign advance = active && !stall;

  // A frozen phase keeps sd_clk level, so a stall never makes an edge
  assign sd_clk    = active && (phase >= EDGE_PHASE);
  assign sample    = advance && (phase == EDGE_PHASE);
  assign frame_end = sample && (nibble_idx == LAST_NIBBLE);

  //////////////////////////////
  // Phase and nibble counters
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (reset || clear) begin
      phase      <= '0;
      nibble_idx <= '0;
      finished   <= 1'b0;
    end else begin
      if (advance) begin
        if (phase == LAST_PHASE) begin
          phase <= '0;
        end else begin
          phase <= phase + 1'b1;
        end
      end
      if (frame_end) begin
        finished <= 1'b1;
      end else if (sample) begin
        nibble_idx <= nibble_idx + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* src/sd_dma_fsm.sv */
`default_nettype none

module sd_dma_fsm (
  input  wire                    CLK,
  input  wire                    reset,
  input  wire                    start_valid,
  input  wire                    partial,
  input  sd_bus_pkg::byte_idx_t  win_start,
  input  sd_bus_pkg::byte_idx_t  win_end,
  input  wire                    stop_early,
  input  wire                    frame_end,
  input  wire                    window_end,
  input  wire                    writer_idle,
  output logic                   start_ready,
  output logic                   run,
  output logic                   clear,
  output logic                   busy,
  output logic                   done,
  output sd_bus_pkg::byte_idx_t  win_lo,
  output sd_bus_pkg::byte_idx_t  win_hi_incl
);

  import sd_bus_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    FINISH
  } dma_state_t;

  dma_state_t state;
  logic       accept;
  logic       early_q;
  logic       end_seen;
  logic       end_event;

  assign start_ready = (state == IDLE);
  assign accept      = start_valid && start_ready;
  assign clear       = accept;
  assign busy        = (state != IDLE);
  assign done        = (state == FINISH);

  // Early stop only counts for a partial request
  assign end_event = early_q ? window_end : frame_end;

  //////////////////////////////
  // Transfer sequencing
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (reset) begin
      state    <= IDLE;
      run      <= 1'b0;
      early_q  <= 1'b0;
      end_seen <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (accept) begin
            state    <= RUN;
            run      <= 1'b1;
            early_q  <= partial && stop_early;
            end_seen <= 1'b0;
          end
        end
        RUN: begin
          // Stop the SD clock at once, then drain the writer
          if (end_event) begin
            run      <= 1'b0;
            end_seen <= 1'b1;
          end
          if ((end_seen || end_event) && writer_idle) begin
            state <= FINISH;
            run   <= 1'b0;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Window bounds, upper one made inclusive (zero wraps to 511)
  always_ff @(posedge CLK) begin
    if (accept) begin
      win_lo      <= partial ? win_start : '0;
      win_hi_incl <= partial ? win_end - 1'b1 : byte_idx_t'(BLOCK_BYTES - 1);
    end
  end

endmodule

`default_nettype wire

/* src/sd_dma_top.sv */
`default_nettype none

module sd_dma_top (
  input  wire                    CLK,
  input  wire                    reset,
  input  wire                    start_valid,
  input  wire                    partial,
  input  sd_bus_pkg::byte_idx_t  win_start,
  input  sd_bus_pkg::byte_idx_t  win_end,
  input  wire                    stop_early,
  input  mem_pkg::sram_addr_t    base_addr,
  input  sd_bus_pkg::nibble_t    sd_dat,
  input  wire                    sram_ready,
  output logic                   start_ready,
  output logic                   busy,
  output logic                   done,
  output logic                   sd_clk,
  output logic                   sram_valid,
  output mem_pkg::sram_addr_t    sram_addr,
  output mem_pkg::byte_t         sram_data
);

  import sd_bus_pkg::*;
  import mem_pkg::*;

  //////////////////////////////
  // Internal nets
  //////////////////////////////

  logic       run;
  logic       clear;
  logic       stall;
  logic       sample;
  logic       frame_end;
  logic       window_end;
  logic       writer_idle;
  frame_cnt_t nibble_idx;
  byte_idx_t  win_lo;
  byte_idx_t  win_hi_incl;
  logic       byte_valid;
  logic       byte_ready;
  byte_t      byte_data;

  sd_dma_fsm u_fsm (
    .CLK         (CLK),
    .reset       (reset),
    .start_valid (start_valid),
    .partial     (partial),
    .win_start   (win_start),
    .win_end     (win_end),
    .stop_early  (stop_early),
    .frame_end   (frame_end),
    .window_end  (window_end),
    .writer_idle (writer_idle),
    .start_ready (start_ready),
    .run         (run),
    .clear       (clear),
    .busy        (busy),
    .done        (done),
    .win_lo      (win_lo),
    .win_hi_incl (win_hi_incl)
  );

  sd_clk_timer u_timer (
    .CLK        (CLK),
    .reset      (reset),
    .run        (run),
    .clear      (clear),
    .stall      (stall),
    .sd_clk     (sd_clk),
    .sample     (sample),
    .nibble_idx (nibble_idx),
    .frame_end  (frame_end)
  );

  nibble_packer u_packer (
    .CLK         (CLK),
    .reset       (reset),
    .clear       (clear),
    .run         (run),
    .sample      (sample),
    .nibble_idx  (nibble_idx),
    .sd_dat      (sd_dat),
    .win_lo      (win_lo),
    .win_hi_incl (win_hi_incl),
    .byte_ready  (byte_ready),
    .byte_valid  (byte_valid),
    .byte_data   (byte_data),
    .stall       (stall),
    .window_end  (window_end)
  );

  sram_writer u_writer (
    .CLK         (CLK),
    .reset       (reset),
    .clear       (clear),
    .base_addr   (base_addr),
    .byte_valid  (byte_valid),
    .byte_data   (byte_data),
    .sram_ready  (sram_ready),
    .byte_ready  (byte_ready),
    .sram_valid  (sram_valid),
    .sram_addr   (sram_addr),
    .sram_data   (sram_data),
    .writer_idle (writer_idle)
  );

endmodule

`default_nettype wire

/* src/sram_writer.sv */
`default_nettype none

module sram_writer (
  input  wire                  CLK,
  input  wire                  reset,
  input  wire                  clear,
  input  mem_pkg::sram_addr_t  base_addr,
  input  wire                  byte_valid,
  input  mem_pkg::byte_t       byte_data,
  input  wire                  sram_ready,
  output logic                 byte_ready,
  output logic                 sram_valid,
  output mem_pkg::sram_addr_t  sram_addr,
  output mem_pkg::byte_t       sram_data,
  output logic                 writer_idle
);

  logic byte_move;
  logic sram_move;

  // Slot is free when empty or being written this cycle
  assign byte_ready  = !sram_valid || sram_ready;
  assign byte_move   = byte_valid && byte_ready;
  assign sram_move   = sram_valid && sram_ready;
  assign writer_idle = !sram_valid && !byte_valid;

  //////////////////////////////
  // Output slot and address
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (reset || clear) begin
      sram_valid <= 1'b0;
    end else if (byte_move) begin
      sram_valid <= 1'b1;
    end else if (sram_move) begin
      sram_valid <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      sram_addr <= '0;
    end else if (clear) begin
      sram_addr <= base_addr;
    end else if (sram_move) begin
      sram_addr <= sram_addr + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (byte_move) begin
      sram_data <= byte_data;
    end
  end

endmodule

`default_nettype wire

/* tests/sd_card_model.sv */
`default_nettype none

module sd_card_model (
  input  wire                  sd_clk,
  input  wire                  arm,
  output sd_bus_pkg::nibble_t  sd_dat
);

  import sd_bus_pkg::*;
  import mem_pkg::*;

  localparam int CRC_FIRST = DATA_FIRST_NIBBLE + 2 * BLOCK_BYTES;
  localparam int STOP_POS  = FRAME_NIBBLES - 1;

  byte_t   data_mem [BLOCK_BYTES];
  int      pos = FRAME_NIBBLES;
  int      frame_rises = 0;
  nibble_t dat_q = 4'hF;

  assign sd_dat = dat_q;

  task automatic load_byte(input int idx, input byte_t value);
    data_mem[idx] = value;
  endtask

  // DAT value at one frame position, idle high past the stop nibble
  function automatic nibble_t nibble_at(input int p);
    int off;
    off = p - DATA_FIRST_NIBBLE;
    if (p < DATA_FIRST_NIBBLE) begin
      return 4'h0;
    end else if (p < CRC_FIRST) begin
      // High half goes out first
      if (off[0]) begin
        return data_mem[off / 2][3:0];
      end
      return data_mem[off / 2][7:4];
    end else if (p < STOP_POS) begin
      return 4'h0;
    end
    return 4'hF;
  endfunction

  //////////////////////////////
  // Frame shifter
  //////////////////////////////

  // Start nibble is on DAT before the first rising edge
  always @(negedge sd_clk or posedge arm) begin
    if (arm) begin
      pos = 0;
    end else if (pos < FRAME_NIBBLES) begin
      pos = pos + 1;
    end
    dat_q = nibble_at(pos);
  end

  always @(posedge sd_clk or posedge arm) begin
    if (arm) begin
      frame_rises = 0;
    end else begin
      frame_rises = frame_rises + 1;
    end
  end

endmodule

`default_nettype wire

/* tests/tb_sd_dma.sv */
`default_nettype none

module tb_sd_dma;

  import sd_bus_pkg::*;
  import mem_pkg::*;

  localparam int RESET_CYCLES   = 10;
  localparam int NUM_FRAMES     = 5;
  localparam int FRAME_CYCLES   = FRAME_NIBBLES * CLKS_PER_SD;
  // Room for back-pressure stalls on every frame
  localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_CYCLES * 4 + RESET_CYCLES;
  localparam int PAT_LEN        = 1024;

  logic       CLK;
  logic       reset;
  logic       start_valid;
  logic       partial;
  byte_idx_t  win_start;
  byte_idx_t  win_end;
  logic       stop_early;
  sram_addr_t base_addr;
  nibble_t    sd_dat;
  logic       sram_ready;
  logic       start_ready;
  logic       busy;
  logic       done;
  logic       sd_clk;
  logic       sram_valid;
  sram_addr_t sram_addr;
  byte_t      sram_data;
  logic       card_arm;

  byte_t      exp_block [BLOCK_BYTES];
  byte_t      wr_data_q [$];
  sram_addr_t wr_addr_q [$];
  bit         ready_pat [PAT_LEN];
  bit         ready_random = 1'b0;
  int         pat_idx = 0;
  int         cycle_count = 0;
  int         done_count = 0;
  int         stall_cycles = 0;
  logic       prev_sd_clk = 1'b0;
  logic       prev_stall = 1'b0;

  sd_dma_top u_dut (
    .CLK         (CLK),
    .reset       (reset),
    .start_valid (start_valid),
    .partial     (partial),
    .win_start   (win_start),
    .win_end     (win_end),
    .stop_early  (stop_early),
    .base_addr   (base_addr),
    .sd_dat      (sd_dat),
    .sram_ready  (sram_ready),
    .start_ready (start_ready),
    .busy        (busy),
    .done        (done),
    .sd_clk      (sd_clk),
    .sram_valid  (sram_valid),
    .sram_addr   (sram_addr),
    .sram_data   (sram_data)
  );

  sd_card_model u_card (
    .sd_clk (sd_clk),
    .arm    (card_arm),
    .sd_dat (sd_dat)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // SRAM side is always ready unless the random pattern is on
  initial begin
    sram_ready = 1'b1;
    forever begin
      @(posedge CLK);
      #1;
      sram_ready = ready_random ? ready_pat[pat_idx] : 1'b1;
      pat_idx = (pat_idx + 1) % PAT_LEN;
    end
  end

  always @(posedge CLK) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SIMULATION FAILED");
      $fatal(1, "run stopped by timeout");
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic stop_on_error();
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic abort_run(input string why);
    $display("Error at %0t: %s", $time, why);
    stop_on_error();
  endtask

  task automatic check_byte(input string what, input byte_t exp, input byte_t got);
    if (got !== exp) begin
      $display("FAIL at %0t: %s expected %02h got %02h", $time, what, exp, got);
      stop_on_error();
    end
  endtask

  task automatic check_addr(input string what, input sram_addr_t exp, input sram_addr_t got);
    if (got !== exp) begin
      $display("FAIL at %0t: %s expected %05h got %05h", $time, what, exp, got);
      stop_on_error();
    end
  endtask

  task automatic check_count(input string what, input int exp, input int got);
    if (got != exp) begin
      $display("FAIL at %0t: %s expected %0d got %0d", $time, what, exp, got);
      stop_on_error();
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic got);
    if (got !== exp) begin
      $display("FAIL at %0t: %s expected %b got %b", $time, what, exp, got);
      stop_on_error();
    end
  endtask

  // Outputs are stable at the falling CLK edge
  always @(negedge CLK) begin
    if (!reset) begin
      if (sram_valid && sram_ready) begin
        wr_addr_q.push_back(sram_addr);
        wr_data_q.push_back(sram_data);
      end
      if (done) begin
        done_count = done_count + 1;
      end
      if (u_dut.stall) begin
        stall_cycles = stall_cycles + 1;
      end
      if (sd_clk && !prev_sd_clk && prev_stall) begin
        abort_run("sd_clk rose right after a cycle in which the DUT was stalled");
      end
      prev_sd_clk = sd_clk;
      prev_stall  = u_dut.stall;
    end
  end

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  function automatic int window_top(input int we);
    return (we == 0) ? BLOCK_BYTES : we;
  endfunction

  task automatic load_random_block();
    for (int i = 0; i < BLOCK_BYTES; i++) begin
      exp_block[i] = byte_t'($urandom);
      u_card.load_byte(i, exp_block[i]);
    end
  endtask

  task automatic arm_card();
    @(posedge CLK);
    #1;
    card_arm = 1'b1;
    #1;
    card_arm = 1'b0;
  endtask

  task automatic send_request(input bit part, input int ws, input int we,
                              input bit early, input int base);
    @(posedge CLK);
    #1;
    start_valid = 1'b1;
    partial     = part;
    win_start   = byte_idx_t'(ws);
    win_end     = byte_idx_t'(we);
    stop_early  = early;
    base_addr   = sram_addr_t'(base);
    @(negedge CLK);
    while (!start_ready) begin
      @(negedge CLK);
    end
    @(posedge CLK);
    #1;
    start_valid = 1'b0;
  endtask

  task automatic wait_for_done(input int done_before);
    while (done_count == done_before) begin
      @(negedge CLK);
    end
  endtask

  task automatic run_transfer(input bit part, input int ws, input int we, input bit early,
                              input int base, output int wr_start);
    int done_before;
    done_before = done_count;
    wr_start = wr_data_q.size();
    arm_card();
    send_request(part, ws, we, early, base);
    wait_for_done(done_before);
    repeat (8) @(negedge CLK);
  endtask

  // Expected writes are block bytes first..last-1 at consecutive addresses
  task automatic check_writes(input int wr_start, input int first, input int last,
                              input int base);
    check_count("number of SRAM writes", last - first, wr_data_q.size() - wr_start);
    for (int i = 0; i < last - first; i++) begin
      check_byte($sformatf("data of write %0d", i), exp_block[first + i],
                 wr_data_q[wr_start + i]);
      check_addr($sformatf("address of write %0d", i), sram_addr_t'(base + i),
                 wr_addr_q[wr_start + i]);
    end
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic test_after_reset();
    int wr_start;
    @(negedge CLK);
    check_flag("start_ready after reset", 1'b1, start_ready);
    check_flag("busy after reset", 1'b0, busy);
    check_flag("sram_valid after reset", 1'b0, sram_valid);
    check_flag("sd_clk after reset", 1'b0, sd_clk);
    wr_start = wr_data_q.size();
    repeat (20) @(negedge CLK);
    check_count("SRAM writes while idle", 0, wr_data_q.size() - wr_start);
  endtask

  task automatic test_full_block();
    int wr_start;
    load_random_block();
    run_transfer(1'b0, 0, 0, 1'b0, 32'h0001_2340, wr_start);
    check_writes(wr_start, 0, BLOCK_BYTES, 32'h0001_2340);
    check_count("SD rising edges of a full block", FRAME_NIBBLES, u_card.frame_rises);
  endtask

  // Window ends inside the block while the frame runs to the stop nibble
  task automatic test_window_full_frame();
    int wr_start;
    load_random_block();
    run_transfer(1'b1, 300, 458, 1'b0, 32'h0000_4000, wr_start);
    check_writes(wr_start, 300, window_top(458), 32'h0000_4000);
    check_count("SD rising edges of a windowed frame", FRAME_NIBBLES, u_card.frame_rises);
  endtask

  task automatic test_window_stop_early();
    int wr_start;
    load_random_block();
    run_transfer(1'b1, 10, 101, 1'b1, 32'h0003_0000, wr_start);
    check_writes(wr_start, 10, window_top(101), 32'h0003_0000);
    check_count("SD rising edges with early stop", 2 * window_top(101) + 1,
                u_card.frame_rises);
  endtask

  task automatic test_back_pressure();
    int wr_start;
    int stall_before;
    load_random_block();
    stall_before = stall_cycles;
    @(negedge CLK);
    ready_random = 1'b1;
    run_transfer(1'b0, 0, 0, 1'b0, 32'h0005_0100, wr_start);
    @(negedge CLK);
    ready_random = 1'b0;
    check_writes(wr_start, 0, BLOCK_BYTES, 32'h0005_0100);
    check_count("SD rising edges under back-pressure", FRAME_NIBBLES, u_card.frame_rises);
    check_flag("SD clock stalled at least once", 1'b1, stall_cycles > stall_before);
  endtask

  // Window end of zero stands for the whole block
  task automatic test_busy_request();
    int wr_start;
    int done_before;
    load_random_block();
    done_before = done_count;
    wr_start = wr_data_q.size();
    arm_card();
    send_request(1'b1, 0, 0, 1'b0, 32'h0002_0000);
    repeat (200) @(posedge CLK);
    #1;
    start_valid = 1'b1;
    base_addr   = sram_addr_t'(32'h0007_0000);
    repeat (16) begin
      @(negedge CLK);
      check_flag("start_ready while busy", 1'b0, start_ready);
    end
    @(posedge CLK);
    #1;
    start_valid = 1'b0;
    wait_for_done(done_before);
    repeat (40) @(negedge CLK);
    check_count("done pulses for one request", 1, done_count - done_before);
    check_flag("busy after the transfer", 1'b0, busy);
    check_writes(wr_start, 0, window_top(0), 32'h0002_0000);
  endtask

  initial begin
    void'($urandom(32'hc64b));
    reset       = 1'b1;
    start_valid = 1'b0;
    partial     = 1'b0;
    win_start   = '0;
    win_end     = '0;
    stop_early  = 1'b0;
    base_addr   = '0;
    card_arm    = 1'b0;
    for (int i = 0; i < PAT_LEN; i++) begin
      ready_pat[i] = ($urandom % 5) == 0;
    end
    repeat (RESET_CYCLES) @(posedge CLK);
    #1;
    reset = 1'b0;

    test_after_reset();
    test_full_block();
    test_window_full_frame();
    test_window_stop_early();
    test_back_pressure();
    test_busy_request();

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire
